//--- source/eeprom_pkg.sv
package eeprom_pkg;

    // 2 KiB part, bits 10..8 pick the 256-byte block
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_byte_t; // parallel data and bus shifter

    // fixed upper nibble of the control byte
    localparam logic [3:0] EE_DEVICE_CODE = 4'b1010;

    // bit engine commands
    // a start while the bus is held gives a repeated start
    typedef enum logic [1:0]
    {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bit_cmd_t;

endpackage

//--- source/i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4 // CLK cycles per quarter SCL period
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_valid,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  eeprom_pkg::ee_byte_t tx_byte,
    input  logic                 tx_ack,
    output logic                 cmd_done,
    output logic                 rx_nack,
    output logic                 idle,
    output eeprom_pkg::ee_byte_t rx_byte,
    output logic                 scl,
    output logic                 sda_pull,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    localparam int QW = $clog2(CLK_DIV);

    typedef enum logic [2:0]
    {
        PH_IDLE,
        PH_START,
        PH_STOP,
        PH_WRITE,
        PH_READ
    } phase_t;

    phase_t phase;
    logic [QW-1:0] qcnt;
    logic [1:0] quarter;
    logic [3:0] bit_cnt;     // 8 is the ack slot after data bits 0..7
    ee_byte_t shreg;
    logic ack_bit;
    logic tick;
    logic last_q;
    logic scl_mid;
    logic scl_nxt;
    logic pull_nxt;

    assign tick = (qcnt == QW'(CLK_DIV - 1));
    assign last_q = (quarter == 2'd3) &&
                    ((phase == PH_START) || (phase == PH_STOP) || (bit_cnt == 4'd8));
    assign scl_mid = quarter[0] ^ quarter[1]; // high in quarters 1 and 2
    assign idle = (phase == PH_IDLE);
    assign rx_byte = shreg;

    // line levels wanted for the current quarter
    always_comb
    begin
        scl_nxt = scl;
        pull_nxt = sda_pull;
        case (phase)
            PH_START:
            begin
                scl_nxt = scl_mid;
                pull_nxt = quarter[1];      // sda falls while scl high
            end
            PH_STOP:
            begin
                scl_nxt = (quarter != 2'd0);
                pull_nxt = ~quarter[1];     // sda rises while scl high
            end
            PH_WRITE:
            begin
                scl_nxt = scl_mid;
                pull_nxt = (bit_cnt < 4'd8) ? ~shreg[7] : 1'b0;
            end
            PH_READ:
            begin
                scl_nxt = scl_mid;
                pull_nxt = (bit_cnt == 4'd8) ? ~ack_bit : 1'b0;
            end
            default: ; // hold levels between commands
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase <= PH_IDLE;
            qcnt <= '0;
            quarter <= '0;
            bit_cnt <= '0;
            cmd_done <= 1'b0;
            scl <= 1'b1;
            sda_pull <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            scl <= scl_nxt;
            sda_pull <= pull_nxt;
            if (phase == PH_IDLE)
            begin
                if (cmd_valid)
                begin
                    case (cmd)
                        CMD_START: phase <= PH_START;
                        CMD_STOP:  phase <= PH_STOP;
                        CMD_WRITE: phase <= PH_WRITE;
                        default:   phase <= PH_READ;
                    endcase
                    qcnt <= '0;
                    quarter <= '0;
                    bit_cnt <= '0;
                end
            end
            else if (tick)
            begin
                qcnt <= '0;
                quarter <= quarter + 2'd1;
                if (last_q)
                begin
                    phase <= PH_IDLE;
                    cmd_done <= 1'b1;
                end
                else if (quarter == 2'd3)
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else
                qcnt <= qcnt + QW'(1);
        end
    end

    // shifter and sampled ack
    always_ff @(posedge CLK)
    begin
        if (idle && cmd_valid && (cmd == CMD_WRITE || cmd == CMD_READ))
        begin
            shreg <= tx_byte;
            ack_bit <= tx_ack;
        end
        else if (tick && bit_cnt < 4'd8)
        begin
            if (phase == PH_WRITE && quarter == 2'd3)
                shreg <= {shreg[6:0], 1'b0}; // msb first
            else if (phase == PH_READ && quarter == 2'd2)
                shreg <= {shreg[6:0], sda_in};
        end
        else if (tick && phase == PH_WRITE && quarter == 2'd2)
            rx_nack <= sda_in; // slave ack slot while scl is high
    end

endmodule

//--- source/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 ack,
    output logic                 err,
    output logic                 busy,
    output logic                 cmd_valid,
    output eeprom_pkg::bit_cmd_t cmd,
    output eeprom_pkg::ee_byte_t tx_byte,
    output logic                 tx_ack,
    input  logic                 cmd_done,
    input  logic                 rx_nack,
    input  logic                 idle,
    input  eeprom_pkg::ee_byte_t rx_byte
);
    import eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_W,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } state_t;

    state_t state;
    ee_addr_t addr_r;
    ee_byte_t wdata_r;
    logic rd_req;
    logic issued;    // command of this state handed to the engine
    logic accept;
    bit_cmd_t next_cmd;
    ee_byte_t next_byte;

    assign accept = (state == IDLE || state == DONE) && (wr || rd);
    assign busy = (state != IDLE) && (state != DONE);
    assign ack = (state == DONE);
    assign tx_ack = 1'b1; // single byte read, always nack

    // bus command belonging to each state
    always_comb
    begin
        next_cmd = CMD_STOP;
        next_byte = '0;
        case (state)
            START, RESTART: next_cmd = CMD_START;
            CTRL_W:
            begin
                next_cmd = CMD_WRITE;
                next_byte = {EE_DEVICE_CODE, addr_r[10:8], 1'b0};
            end
            ADDR:
            begin
                next_cmd = CMD_WRITE;
                next_byte = addr_r[7:0];
            end
            DATA_W:
            begin
                next_cmd = CMD_WRITE;
                next_byte = wdata_r;
            end
            CTRL_R:
            begin
                next_cmd = CMD_WRITE;
                next_byte = {EE_DEVICE_CODE, addr_r[10:8], 1'b1};
            end
            DATA_R: next_cmd = CMD_READ;
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            rd_req <= 1'b0;
            issued <= 1'b0;
            err <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            if (accept)
            begin
                state <= START;
                rd_req <= ~wr; // wr wins over rd
                err <= 1'b0;
            end
            else if (state == DONE)
                state <= IDLE;
            else if (busy && !issued && idle)
            begin
                cmd_valid <= 1'b1;
                issued <= 1'b1;
            end
            else if (cmd_done)
            begin
                issued <= 1'b0;
                case (state)
                    START:   state <= CTRL_W;
                    RESTART: state <= CTRL_R;
                    CTRL_W:  state <= rx_nack ? STOP : ADDR;
                    ADDR:    state <= rx_nack ? STOP : (rd_req ? RESTART : DATA_W);
                    CTRL_R:  state <= rx_nack ? STOP : DATA_R;
                    DATA_W, DATA_R: state <= STOP;
                    default: state <= DONE; // stop finished
                endcase
                if (state inside {CTRL_W, ADDR, DATA_W, CTRL_R})
                    err <= err | rx_nack;
            end
        end
    end

    // request and command payload
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_r <= addr;
            wdata_r <= wdata;
        end
        if (busy && !issued && idle)
        begin
            cmd <= next_cmd;
            tx_byte <= next_byte;
        end
        if (state == STOP && cmd_done && rd_req && !err)
            rdata <= rx_byte; // visible with ack
    end

endmodule

//--- source/eeprom_if_top.sv
`timescale 1ns/1ps

module eeprom_if_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 wr,
    input  logic                 rd,
    input  eeprom_pkg::ee_addr_t addr,
    input  eeprom_pkg::ee_byte_t wdata,
    output eeprom_pkg::ee_byte_t rdata,
    output logic                 ack,
    output logic                 err,
    output logic                 busy,
    output logic                 scl,
    output logic                 sda_pull,
    input  logic                 sda_in
);
    import eeprom_pkg::*;

    logic cmd_valid;
    bit_cmd_t cmd;
    ee_byte_t tx_byte;
    logic tx_ack;
    logic cmd_done;
    logic rx_nack;
    logic idle;
    ee_byte_t rx_byte;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .ack       (ack),
        .err       (err),
        .busy      (busy),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .cmd_done  (cmd_done),
        .rx_nack   (rx_nack),
        .idle      (idle),
        .rx_byte   (rx_byte)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack),
        .cmd_done  (cmd_done),
        .rx_nack   (rx_nack),
        .idle      (idle),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

endmodule

//--- verif/eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_pull
);
    import eeprom_pkg::*;

    ee_byte_t mem [0:2047];
    logic scl_q;
    logic sda_q;
    logic active;          // addressed, until stop or nack
    logic reading;
    logic sending;         // driving read data
    logic ack_now;
    logic [1:0] byte_pos;  // 0 control, 1 address, 2 data
    logic [3:0] bit_cnt;
    ee_byte_t shreg;
    ee_byte_t out_sh;
    ee_addr_t ptr;

    function automatic ee_byte_t fill_byte(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], 5'h0b};
    endfunction

    task automatic take_byte();
        ack_now = !force_nack;
        case (byte_pos)
            2'd0:
            begin
                if (shreg[7:4] != EE_DEVICE_CODE)
                    ack_now = 1'b0;
                reading = shreg[0];
                ptr = {shreg[3:1], ptr[7:0]}; // block bits
            end
            2'd1: ptr = {ptr[10:8], shreg};
            default:
            begin
                if (ack_now)
                    mem[ptr] = shreg;
            end
        endcase
        if (byte_pos != 2'd2)
            byte_pos = byte_pos + 2'd1;
        if (!ack_now)
        begin
            active = 1'b0;
            reading = 1'b0;
        end
    endtask

    task automatic scl_rise();
        if (bit_cnt < 4'd8)
        begin
            shreg = {shreg[6:0], sda};
            out_sh = {out_sh[6:0], 1'b0};
            bit_cnt = bit_cnt + 4'd1;
            if (bit_cnt == 4'd8 && !sending)
                take_byte();
        end
        else
        begin
            bit_cnt = 4'd0;
            if (sending && sda)
                active = 1'b0; // master nack ends the read
            else if (reading)
            begin
                sending = 1'b1;
                out_sh = mem[ptr];
            end
        end
    endtask

    // outputs only change while scl is low
    task automatic scl_fall();
        sda_pull = 1'b0;
        if (active)
        begin
            if (bit_cnt == 4'd8)
                sda_pull = ack_now && !sending;
            else if (sending)
                sda_pull = ~out_sh[7];
        end
    endtask

    initial
    begin
        ee_addr_t a;
        a = '0;
        repeat (2048)
        begin
            mem[a] = fill_byte(a);
            a = a + 11'd1;
        end
        scl_q = 1'b1;
        sda_q = 1'b1;
        active = 1'b0;
        reading = 1'b0;
        sending = 1'b0;
        ack_now = 1'b0;
        byte_pos = 2'd0;
        bit_cnt = 4'd0;
        ptr = '0;
        sda_pull = 1'b0;
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            active = 1'b1; // start or repeated start
            reading = 1'b0;
            sending = 1'b0;
            byte_pos = 2'd0;
            bit_cnt = 4'd0;
        end
        else if (scl && scl_q && !sda_q && sda)
            active = 1'b0; // stop
        else if (scl && !scl_q && active)
            scl_rise();
        else if (!scl && scl_q)
            scl_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- verif/tb_eeprom_if_top.sv
`timescale 1ns/1ps

module tb_eeprom_if_top;
    import eeprom_pkg::*;

    localparam int TIMEOUT = 5000; // CLK cycles per wait

    logic CLK;
    logic RESET;
    logic wr;
    logic rd;
    ee_addr_t addr;
    ee_byte_t wdata;
    ee_byte_t rdata;
    logic ack;
    logic err;
    logic busy;
    logic scl;
    logic sda_pull;
    logic sda_in;
    logic model_pull;
    logic force_nack;

    ee_byte_t ref_mem [0:2047];
    logic [15:0] lfsr;
    int check_errors;
    int timeout_errors;

    assign sda_in = ~(sda_pull | model_pull); // wired and with pull-up

    eeprom_if_top #(
        .CLK_DIV (4)
    ) dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .err      (err),
        .busy     (busy),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

    eeprom_model model0 (
        .scl        (scl),
        .sda        (sda_in),
        .force_nack (force_nack),
        .sda_pull   (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic ee_byte_t fill_byte(input ee_addr_t a);
        return a[7:0] ^ {a[10:8], 5'h0b};
    endfunction

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %s got %0h expected %0h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic wait_ack(input string what, output logic seen);
        int n;
        n = 0;
        while (ack !== 1'b1 && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        seen = (ack === 1'b1);
        if (seen)
            compare("busy", 32'(busy), 32'd0); // busy drops with ack
        else
        begin
            $display("timeout: no ack for the %s", what);
            timeout_errors++;
        end
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (busy !== 1'b1 && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (busy !== 1'b1)
        begin
            $display("timeout: busy never rose after a request");
            timeout_errors++;
        end
    endtask

    task automatic request(input logic is_wr, input ee_addr_t a, input ee_byte_t d);
        @(negedge CLK);
        wr = is_wr;
        rd = ~is_wr;
        addr = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic write_byte(input ee_addr_t a, input ee_byte_t d, input logic exp_err);
        logic seen;
        request(1'b1, a, d);
        wait_ack("write", seen);
        if (seen)
            compare("err", 32'(err), 32'(exp_err));
        if (!exp_err)
            ref_mem[a] = d;
    endtask

    task automatic read_byte(input ee_addr_t a, input logic exp_err);
        logic seen;
        request(1'b0, a, '0);
        wait_ack("read", seen);
        if (seen)
        begin
            compare("err", 32'(err), 32'(exp_err));
            if (!exp_err)
                compare($sformatf("rdata[%0h]", a), 32'(rdata), 32'(ref_mem[a]));
        end
    endtask

    task automatic reset_state_quiet();
        repeat (8)
        begin
            repeat (16) @(negedge CLK); // one scl period
            compare("scl", 32'(scl), 32'd1);
            compare("sda_pull", 32'(sda_pull), 32'd0);
            compare("ack", 32'(ack), 32'd0);
            compare("busy", 32'(busy), 32'd0);
            compare("err", 32'(err), 32'd0);
        end
    endtask

    task automatic write_read_back();
        write_byte(11'h05a, 8'hc3, 1'b0);
        read_byte(11'h05a, 1'b0);
    endtask

    task automatic block_select();
        for (int b = 0; b < 8; b++)
            write_byte({3'(b), 8'h3c}, ee_byte_t'(8'h90 + b), 1'b0);
        for (int b = 0; b < 8; b++)
            read_byte({3'(b), 8'h3c}, 1'b0);
    endtask

    task automatic random_traffic();
        ee_addr_t addrs [$];
        ee_addr_t a;
        repeat (16)
        begin
            a = ee_addr_t'(rand_bits(11));
            addrs.push_back(a);
            write_byte(a, ee_byte_t'(rand_bits(8)), 1'b0);
        end
        foreach (addrs[i])
            read_byte(addrs[i], 1'b0);
    endtask

    task automatic device_nack();
        force_nack = 1'b1;
        write_byte(11'h05a, 8'h77, 1'b1);
        compare("scl", 32'(scl), 32'd1);
        compare("sda_pull", 32'(sda_pull), 32'd0);
        read_byte(11'h05a, 1'b1);
        compare("scl", 32'(scl), 32'd1);
        compare("sda_pull", 32'(sda_pull), 32'd0);
        force_nack = 1'b0;
        read_byte(11'h05a, 1'b0); // old byte still there
    endtask

    task automatic busy_request_ignored();
        logic seen;
        request(1'b1, 11'h2a5, 8'h4e);
        wait_busy();
        request(1'b1, 11'h6b1, 8'hd2); // dropped while the controller is busy
        wait_ack("write with a request while busy", seen);
        if (seen)
            compare("err", 32'(err), 32'd0);
        ref_mem[11'h2a5] = 8'h4e;
        read_byte(11'h6b1, 1'b0);
        read_byte(11'h2a5, 1'b0);
    endtask

    initial
    begin
        ee_addr_t a;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        force_nack = 1'b0;
        lfsr = 16'd6;
        check_errors = 0;
        timeout_errors = 0;
        a = '0;
        repeat (2048)
        begin
            ref_mem[a] = fill_byte(a);
            a = a + 11'd1;
        end
        repeat (3) @(negedge CLK);
        RESET = 1'b0;
        reset_state_quiet();
        write_read_back();
        block_select();
        random_traffic();
        device_nack();
        busy_request_ignored();
        $display("check errors %0d, timeouts %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- eeprom_if_top.f
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_ctrl.sv
source/eeprom_if_top.sv
verif/eeprom_model.sv
verif/tb_eeprom_if_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_if_top
FILELIST  ?= eeprom_if_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= No errors

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
